/* src/cpuPackage.sv */
`default_nettype none

package cpuPackage;

    // ========================================
    // Widths and timing
    // ========================================
    localparam int StepCount = 12;

    typedef logic [7:0]           byteT;
    typedef logic [7:0]           addressT;
    typedef logic [15:0]          wordT;
    typedef logic [1:0]           regIndexT;
    typedef logic [StepCount-1:0] timeStepT;

    localparam timeStepT StepT0 = 12'h001;
    localparam timeStepT StepT1 = 12'h002;
    localparam timeStepT StepT2 = 12'h004;
    localparam timeStepT StepT3 = 12'h008;
    localparam timeStepT StepT4 = 12'h010;
    localparam timeStepT StepT5 = 12'h020;
    localparam timeStepT StepT6 = 12'h040;

    // ========================================
    // Instruction format
    // ========================================
    typedef enum logic [5:0] {
        OpBra   = 6'h00,
        OpBne   = 6'h01,
        OpBeq   = 6'h02,
        OpInc   = 6'h09,
        OpDec   = 6'h0A,
        OpAdd   = 6'h15,
        OpSub   = 6'h17,
        OpMovl  = 6'h19,
        OpMovsh = 6'h1A,
        OpLdal  = 6'h1E,
        OpSta   = 6'h20
    } opcodeT;

    typedef struct packed {
        opcodeT   opcode;   // High byte, bits 15:10
        regIndexT regSel;
        byteT     operand;  // Low byte, fetched first
    } instructionT;

    // ========================================
    // Function encodings
    // ========================================
    typedef enum logic [1:0] {RfHold, RfLoad, RfLoadLow, RfShiftLoad} rfFunctionT;
    typedef enum logic [2:0] {AluPassB, AluAdd, AluSub, AluInc, AluDec} aluFunctionT;
    typedef enum logic [1:0] {ArfHold, ArfIncrement, ArfLoad} arfFunctionT;
    typedef enum logic {SelPc, SelAr} arfSelectT;
    typedef enum logic [1:0] {MuxAlu, MuxImmediate, MuxDataReg} muxASourceT;

    typedef struct packed {
        rfFunctionT  rfFunction;
        regIndexT    rfWriteIndex;
        regIndexT    rfReadA;
        regIndexT    rfReadB;
        aluFunctionT aluFunction;
        logic        flagWrite;
        arfFunctionT arfFunction;
        arfSelectT   arfSelect;
        arfSelectT   memAddressSource;
        logic        memWrite;
        logic        storeHigh;    // Store byte 15:8 instead of 7:0
        logic        irLoad;
        logic        drLoad;
        logic        loadHigh;     // Shared by IR and DR
        muxASourceT  muxASource;
    } controlT;

    typedef struct packed {
        addressT address;
        byteT    writeData;
        logic    write;
    } memoryRequestT;

endpackage

`default_nettype wire

/* src/byteAssembler.sv */
`default_nettype none

module byteAssembler #(
    parameter type payloadT = cpuPackage::wordT
) (
    input  wire                   Clock,
    input  wire                   Reset,
    input  wire                   load,
    input  wire                   loadHigh,
    input  wire cpuPackage::byteT byteIn,
    output payloadT               value
);

    logic [$bits(payloadT)-1:0] storage;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            storage <= '0;
        end else if (load) begin
            if (loadHigh) begin
                storage[$bits(payloadT)-1 -: 8] <= byteIn;  // Upper byte
            end else begin
                storage[7:0] <= byteIn;
            end
        end
    end

    assign value = payloadT'(storage);

endmodule

`default_nettype wire

/* src/registerFile.sv */
`default_nettype none

module registerFile (
    input  wire                         Clock,
    input  wire                         Reset,
    input  wire cpuPackage::rfFunctionT functionSel,
    input  wire cpuPackage::regIndexT   writeIndex,
    input  wire cpuPackage::wordT       writeData,
    input  wire cpuPackage::regIndexT   readIndexA,
    input  wire cpuPackage::regIndexT   readIndexB,
    output cpuPackage::wordT            readA,
    output cpuPackage::wordT            readB
);

    cpuPackage::wordT registers [4];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 4; i++) begin
                registers[i] <= '0;
            end
        end else begin
            case (functionSel)
                cpuPackage::RfLoad:      registers[writeIndex] <= writeData;
                cpuPackage::RfLoadLow:   registers[writeIndex] <= {8'h00, writeData[7:0]};
                cpuPackage::RfShiftLoad: begin
                    // Old low byte moves up
                    registers[writeIndex] <= {registers[writeIndex][7:0], writeData[7:0]};
                end
                default: ;
            endcase
        end
    end

    assign readA = registers[readIndexA];
    assign readB = registers[readIndexB];

endmodule

`default_nettype wire

/* src/addressRegisterFile.sv */
`default_nettype none

module addressRegisterFile (
    input  wire                          Clock,
    input  wire                          Reset,
    input  wire cpuPackage::arfFunctionT functionSel,
    input  wire cpuPackage::arfSelectT   select,
    input  wire cpuPackage::addressT     loadValue,
    output cpuPackage::addressT          pc,
    output cpuPackage::addressT          ar
);

    cpuPackage::addressT current;
    cpuPackage::addressT updated;

    assign current = (select == cpuPackage::SelPc) ? pc : ar;

    always_comb begin
        case (functionSel)
            cpuPackage::ArfIncrement: updated = current + 8'd1;  // Wraps at 256
            cpuPackage::ArfLoad:      updated = loadValue;
            default:                  updated = current;
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
            ar <= '0;
        end else if (select == cpuPackage::SelPc) begin
            pc <= updated;
        end else begin
            ar <= updated;
        end
    end

endmodule

`default_nettype wire

/* src/arithmeticLogicUnit.sv */
`default_nettype none

module arithmeticLogicUnit (
    input  wire                          Clock,
    input  wire                          Reset,
    input  wire cpuPackage::aluFunctionT functionSel,
    input  wire                          flagWrite,
    input  wire cpuPackage::wordT        operandA,
    input  wire cpuPackage::wordT        operandB,
    output cpuPackage::wordT             result,
    output logic                         zeroFlag
);

    // ========================================
    // Result path
    // ========================================
    always_comb begin
        case (functionSel)
            cpuPackage::AluAdd: result = operandA + operandB;
            cpuPackage::AluSub: result = operandA - operandB;
            cpuPackage::AluInc: result = operandA + 16'd1;
            cpuPackage::AluDec: result = operandA - 16'd1;
            default:            result = operandB;  // Pass B for stores
        endcase
    end

    // Zero flag, written only by arithmetic steps
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            zeroFlag <= 1'b0;
        end else if (flagWrite) begin
            zeroFlag <= (result == 16'h0000);
        end
    end

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  wire                      Clock,
    input  wire                      Reset,
    input  wire cpuPackage::instructionT instruction,
    input  wire                      zeroFlag,
    output cpuPackage::controlT      control,
    output cpuPackage::timeStepT     timeStep
);

    logic endStep;
    logic branchTaken;

    // ========================================
    // Timing ring
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            timeStep <= cpuPackage::StepT0;
        end else if (endStep) begin
            timeStep <= cpuPackage::StepT0;
        end else begin
            timeStep <= {timeStep[cpuPackage::StepCount-2:0],
                         timeStep[cpuPackage::StepCount-1]};
        end
    end

    always_comb begin
        case (instruction.opcode)
            cpuPackage::OpBra: branchTaken = 1'b1;
            cpuPackage::OpBne: branchTaken = !zeroFlag;
            cpuPackage::OpBeq: branchTaken = zeroFlag;
            default:           branchTaken = 1'b0;
        endcase
    end

    // ========================================
    // Control generation per step
    // ========================================
    always_comb begin
        control = '0;  // Hold everything, address from PC
        endStep = 1'b0;
        control.rfWriteIndex = instruction.regSel;
        control.rfReadA = instruction.regSel;
        control.rfReadB = instruction.regSel;
        case (timeStep)
            cpuPackage::StepT0: begin
                control.irLoad = 1'b1;                        // Low byte of IR
                control.arfFunction = cpuPackage::ArfIncrement;
            end
            cpuPackage::StepT1: begin
                control.irLoad = 1'b1;
                control.loadHigh = 1'b1;
            end
            cpuPackage::StepT2: begin
                control.arfFunction = cpuPackage::ArfIncrement;
            end
            cpuPackage::StepT3: begin
                case (instruction.opcode)
                    cpuPackage::OpBra, cpuPackage::OpBne, cpuPackage::OpBeq: begin
                        if (branchTaken) begin
                            control.arfFunction = cpuPackage::ArfLoad;  // PC <- operand
                        end
                        endStep = 1'b1;
                    end
                    cpuPackage::OpInc, cpuPackage::OpDec,
                    cpuPackage::OpAdd, cpuPackage::OpSub: begin
                        control.rfFunction = cpuPackage::RfLoad;
                        control.rfReadB = instruction.operand[1:0];  // Second source
                        control.flagWrite = 1'b1;
                        control.muxASource = cpuPackage::MuxAlu;
                        case (instruction.opcode)
                            cpuPackage::OpInc: control.aluFunction = cpuPackage::AluInc;
                            cpuPackage::OpDec: control.aluFunction = cpuPackage::AluDec;
                            cpuPackage::OpAdd: control.aluFunction = cpuPackage::AluAdd;
                            default:           control.aluFunction = cpuPackage::AluSub;
                        endcase
                        endStep = 1'b1;
                    end
                    cpuPackage::OpMovl: begin
                        control.rfFunction = cpuPackage::RfLoadLow;
                        control.muxASource = cpuPackage::MuxImmediate;
                        endStep = 1'b1;
                    end
                    cpuPackage::OpMovsh: begin
                        control.rfFunction = cpuPackage::RfShiftLoad;
                        control.muxASource = cpuPackage::MuxImmediate;
                        endStep = 1'b1;
                    end
                    cpuPackage::OpLdal, cpuPackage::OpSta: begin
                        control.arfFunction = cpuPackage::ArfLoad;  // AR <- operand
                        control.arfSelect = cpuPackage::SelAr;
                    end
                    default: endStep = 1'b1;  // Unused opcode
                endcase
            end
            cpuPackage::StepT4, cpuPackage::StepT5: begin
                control.memAddressSource = cpuPackage::SelAr;
                control.loadHigh = timeStep[5];
                control.storeHigh = timeStep[5];
                if (timeStep[4]) begin
                    control.arfFunction = cpuPackage::ArfIncrement;
                    control.arfSelect = cpuPackage::SelAr;
                end
                if (instruction.opcode == cpuPackage::OpSta) begin
                    control.memWrite = 1'b1;
                    control.aluFunction = cpuPackage::AluPassB;  // Rx through ALU
                    endStep = timeStep[5];
                end else begin
                    control.drLoad = 1'b1;
                end
            end
            cpuPackage::StepT6: begin
                control.rfFunction = cpuPackage::RfLoad;  // Rx <- DR
                control.muxASource = cpuPackage::MuxDataReg;
                endStep = 1'b1;
            end
            default: endStep = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* src/cpuDatapath.sv */
`default_nettype none

module cpuDatapath (
    input  wire                    Clock,
    input  wire                    Reset,
    input  wire cpuPackage::controlT control,
    input  wire cpuPackage::byteT  readData,
    output cpuPackage::instructionT instruction,
    output logic                   zeroFlag,
    output cpuPackage::memoryRequestT memRequest
);

    cpuPackage::wordT    readA;
    cpuPackage::wordT    readB;
    cpuPackage::wordT    aluResult;
    cpuPackage::wordT    dataRegister;
    cpuPackage::wordT    muxA;
    cpuPackage::addressT pc;
    cpuPackage::addressT ar;

    // ========================================
    // Register write source
    // ========================================
    always_comb begin
        case (control.muxASource)
            cpuPackage::MuxAlu:       muxA = aluResult;
            cpuPackage::MuxImmediate: muxA = {8'h00, instruction.operand};
            default:                  muxA = dataRegister;
        endcase
    end

    registerFile generalRegisters (
        .Clock(Clock),
        .Reset(Reset),
        .functionSel(control.rfFunction),
        .writeIndex(control.rfWriteIndex),
        .writeData(muxA),
        .readIndexA(control.rfReadA),
        .readIndexB(control.rfReadB),
        .readA(readA),
        .readB(readB)
    );

    arithmeticLogicUnit alu (
        .Clock(Clock),
        .Reset(Reset),
        .functionSel(control.aluFunction),
        .flagWrite(control.flagWrite),
        .operandA(readA),
        .operandB(readB),
        .result(aluResult),
        .zeroFlag(zeroFlag)
    );

    addressRegisterFile addressRegisters (
        .Clock(Clock),
        .Reset(Reset),
        .functionSel(control.arfFunction),
        .select(control.arfSelect),
        .loadValue(instruction.operand),  // Branch target or data address
        .pc(pc),
        .ar(ar)
    );

    byteAssembler #(.payloadT(cpuPackage::instructionT)) instructionRegister (
        .Clock(Clock),
        .Reset(Reset),
        .load(control.irLoad),
        .loadHigh(control.loadHigh),
        .byteIn(readData),
        .value(instruction)
    );

    byteAssembler #(.payloadT(cpuPackage::wordT)) dataRegisterUnit (
        .Clock(Clock),
        .Reset(Reset),
        .load(control.drLoad),
        .loadHigh(control.loadHigh),
        .byteIn(readData),
        .value(dataRegister)
    );

    // Memory request
    assign memRequest.address = (control.memAddressSource == cpuPackage::SelPc) ? pc : ar;
    assign memRequest.writeData = control.storeHigh ? aluResult[15:8] : aluResult[7:0];
    assign memRequest.write = control.memWrite;

endmodule

`default_nettype wire

/* src/cpuSystem.sv */
`default_nettype none

module cpuSystem (
    input  wire                       Clock,
    input  wire                       Reset,
    input  wire cpuPackage::byteT     readData,
    output cpuPackage::memoryRequestT memRequest,
    output cpuPackage::timeStepT      timeStep
);

    cpuPackage::controlT     control;
    cpuPackage::instructionT instruction;
    logic                    zeroFlag;

    controlUnit controller (
        .Clock(Clock),
        .Reset(Reset),
        .instruction(instruction),
        .zeroFlag(zeroFlag),
        .control(control),
        .timeStep(timeStep)
    );

    cpuDatapath datapath (
        .Clock(Clock),
        .Reset(Reset),
        .control(control),
        .readData(readData),
        .instruction(instruction),
        .zeroFlag(zeroFlag),
        .memRequest(memRequest)
    );

endmodule

`default_nettype wire

/* tests/cpuSystemTb.sv */
`default_nettype none

module cpuSystemTb;

    localparam int InstructionCount = 400;
    localparam int TimeoutCycles = InstructionCount * 7 + 50;  // Longest instruction is 7 cycles

    logic                      Clock;
    logic                      Reset;
    cpuPackage::byteT          readData;
    cpuPackage::memoryRequestT memRequest;
    cpuPackage::timeStepT      timeStep;

    cpuPackage::byteT programImage [256];  // Loaded into memory during reset
    cpuPackage::byteT memory [256];        // Memory seen by the DUT
    cpuPackage::byteT modelMemory [256];

    // ========================================
    // Reference model state
    // ========================================
    cpuPackage::addressT modelPc;
    cpuPackage::wordT    modelRegisters [4];
    logic                modelZero;

    int                  expectedCycles;   // Length of the current instruction
    cpuPackage::addressT fetchAddress;
    cpuPackage::addressT dataAddress;      // First byte of a load or store
    logic                accessesData;
    logic                isStore;
    cpuPackage::wordT    storeWord;

    int cycleCount = 0;

    cpuSystem dut_i (
        .Clock(Clock),
        .Reset(Reset),
        .readData(readData),
        .memRequest(memRequest),
        .timeStep(timeStep)
    );

    always #10 Clock = ~Clock;

    assign readData = memory[memRequest.address];  // Same-cycle read

    always @(posedge Clock) begin
        if (Reset) begin
            for (int a = 0; a < 256; a++) begin
                memory[cpuPackage::addressT'(a)] <= programImage[cpuPackage::addressT'(a)];
            end
        end else if (memRequest.write) begin
            memory[memRequest.address] <= memRequest.writeData;
        end
    end

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            $display("Timeout: the program did not finish within %0d cycles", TimeoutCycles);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Weighted toward the implemented opcodes
    function automatic cpuPackage::instructionT randomInstruction();
        cpuPackage::instructionT instr;
        int pick;
        pick = int'($urandom_range(0, 24));
        instr.regSel = cpuPackage::regIndexT'($urandom_range(0, 3));
        instr.operand = cpuPackage::byteT'($urandom_range(0, 255));
        case (pick)
            0:          instr.opcode = cpuPackage::OpBra;
            1, 2:       instr.opcode = cpuPackage::OpBne;
            3, 4:       instr.opcode = cpuPackage::OpBeq;
            5, 6:       instr.opcode = cpuPackage::OpInc;
            7, 8:       instr.opcode = cpuPackage::OpDec;
            9, 10:      instr.opcode = cpuPackage::OpAdd;
            11, 12:     instr.opcode = cpuPackage::OpSub;
            13, 14, 15: instr.opcode = cpuPackage::OpMovl;
            16, 17:     instr.opcode = cpuPackage::OpMovsh;
            18, 19, 20: instr.opcode = cpuPackage::OpLdal;
            21, 22, 23: instr.opcode = cpuPackage::OpSta;
            default:    instr.opcode = cpuPackage::opcodeT'({2'b11, instr.operand[3:0]});
        endcase
        if (instr.opcode inside {cpuPackage::OpBra, cpuPackage::OpBne, cpuPackage::OpBeq}) begin
            instr.operand[0] = 1'b0;  // Even targets
        end
        if (instr.opcode == cpuPackage::OpLdal || instr.opcode == cpuPackage::OpSta) begin
            instr.operand = {3'b111, instr.operand[4:0]};  // Top 32 bytes
            if (instr.operand[4:2] == 3'b000) begin
                instr.operand = 8'hFF;  // Second byte wraps to 00
            end
        end
        return instr;
    endfunction

    // One whole instruction of the reference model
    task automatic stepModel();
        cpuPackage::instructionT instr;
        cpuPackage::addressT     nextAddress;
        cpuPackage::regIndexT    x;
        cpuPackage::regIndexT    y;
        cpuPackage::wordT        result;
        logic                    taken;
        fetchAddress = modelPc;
        nextAddress = modelPc + 8'd1;
        instr = cpuPackage::instructionT'({modelMemory[nextAddress], modelMemory[modelPc]});
        x = instr.regSel;
        y = instr.operand[1:0];
        nextAddress = instr.operand + 8'd1;
        modelPc = modelPc + 8'd2;
        expectedCycles = 4;
        accessesData = 1'b0;
        isStore = 1'b0;
        case (instr.opcode)
            cpuPackage::OpBra, cpuPackage::OpBne, cpuPackage::OpBeq: begin
                taken = (instr.opcode == cpuPackage::OpBra)
                    || (instr.opcode == cpuPackage::OpBne && !modelZero)
                    || (instr.opcode == cpuPackage::OpBeq && modelZero);
                if (taken) begin
                    modelPc = instr.operand;
                end
            end
            cpuPackage::OpInc, cpuPackage::OpDec, cpuPackage::OpAdd, cpuPackage::OpSub: begin
                case (instr.opcode)
                    cpuPackage::OpInc: result = modelRegisters[x] + 16'd1;
                    cpuPackage::OpDec: result = modelRegisters[x] - 16'd1;
                    cpuPackage::OpAdd: result = modelRegisters[x] + modelRegisters[y];
                    default:           result = modelRegisters[x] - modelRegisters[y];
                endcase
                modelRegisters[x] = result;
                modelZero = (result == 16'h0000);
            end
            cpuPackage::OpMovl: modelRegisters[x] = {8'h00, instr.operand};
            cpuPackage::OpMovsh: modelRegisters[x] = {modelRegisters[x][7:0], instr.operand};
            cpuPackage::OpLdal: begin
                expectedCycles = 7;
                accessesData = 1'b1;
                dataAddress = instr.operand;
                modelRegisters[x] = {modelMemory[nextAddress], modelMemory[instr.operand]};
            end
            cpuPackage::OpSta: begin
                expectedCycles = 6;
                accessesData = 1'b1;
                isStore = 1'b1;
                dataAddress = instr.operand;
                storeWord = modelRegisters[x];
                modelMemory[instr.operand] = storeWord[7:0];  // Low byte first
                modelMemory[nextAddress] = storeWord[15:8];
            end
            default: ;
        endcase
    endtask

    // ========================================
    // Stimulus and checks
    // ========================================
    initial begin
        cpuPackage::instructionT instr;
        cpuPackage::addressT     expectedAddress;
        logic                    writeExpected;
        Clock = 1'b0;
        Reset = 1'b1;
        void'($urandom(32'h069d_f7ef));
        for (int a = 0; a < 256; a += 2) begin
            instr = randomInstruction();
            programImage[cpuPackage::addressT'(a)] = instr[7:0];
            programImage[cpuPackage::addressT'(a + 1)] = instr[15:8];
        end
        for (int a = 0; a < 256; a++) begin
            modelMemory[cpuPackage::addressT'(a)] = programImage[cpuPackage::addressT'(a)];
        end
        for (int r = 0; r < 4; r++) begin
            modelRegisters[cpuPackage::regIndexT'(r)] = '0;
        end
        modelPc = '0;
        modelZero = 1'b0;
        repeat (5) @(negedge Clock);
        Reset = 1'b0;

        checkValue("timeStep", 32'(timeStep), 32'(cpuPackage::StepT0));  // State after reset
        checkValue("memRequest.write", 32'(memRequest.write), 32'(0));
        checkValue("memRequest.address", 32'(memRequest.address), 32'(0));

        for (int n = 0; n < InstructionCount; n++) begin
            stepModel();
            for (int cycle = 0; cycle < expectedCycles; cycle++) begin
                checkValue("timeStep", 32'(timeStep), 32'(1) << cycle);
                if (cycle < 2) begin
                    expectedAddress = fetchAddress + cpuPackage::addressT'(cycle);
                    checkValue("memRequest.address", 32'(memRequest.address),
                               32'(expectedAddress));
                end
                if (accessesData && (cycle == 4 || cycle == 5)) begin
                    expectedAddress = dataAddress + cpuPackage::addressT'(cycle - 4);
                    checkValue("memRequest.address", 32'(memRequest.address),
                               32'(expectedAddress));
                end
                writeExpected = isStore && (cycle == 4 || cycle == 5);
                checkValue("memRequest.write", 32'(memRequest.write), 32'(writeExpected));
                if (writeExpected) begin
                    checkValue("memRequest.writeData", 32'(memRequest.writeData),
                               32'(cycle == 4 ? storeWord[7:0] : storeWord[15:8]));
                end
                @(negedge Clock);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/cpuPackage.sv
src/byteAssembler.sv
src/registerFile.sv
src/addressRegisterFile.sv
src/arithmeticLogicUnit.sv
src/controlUnit.sv
src/cpuDatapath.sv
src/cpuSystem.sv
tests/cpuSystemTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cpuSystemTb -f project.f -o cpuSystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpuSystemSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
